// ==== include/pingpong_consts.svh ====
// Ping-pong buffer constants

`ifndef PINGPONG_CONSTS_SVH
`define PINGPONG_CONSTS_SVH

// ==============================
// Sample format
// ==============================

`define PP_DATA_WIDTH 16    // Bits per sample

// ==============================
// Bank geometry
// ==============================

`define PP_DEPTH      16    // Samples per bank
`define PP_ADDR_WIDTH 4     // log2 of PP_DEPTH

`endif

// ==== rtl/pingpong_pkg.sv ====
// Ping-pong buffer types

`default_nettype none

`include "pingpong_consts.svh"

package pingpong_pkg;

    // One signed sample as carried on both handshakes
    typedef logic signed [`PP_DATA_WIDTH-1:0] sample_t;

    // Address inside a single bank
    typedef logic [`PP_ADDR_WIDTH-1:0] addr_t;

    // One bit wider than addr_t so a full bank is countable
    typedef logic [`PP_ADDR_WIDTH:0] count_t;

    // Buffer state machine encoding
    typedef enum logic [1:0] {
        WRITING      = 2'd0,  // First bank filling, nothing to read yet
        SWAP_PENDING = 2'd1,  // Write bank full, swap at next edge
        READING      = 2'd2   // Reading one bank while filling the other
    } buf_state_t;

endpackage

`default_nettype wire

// ==== rtl/pingpong_bank.sv ====
// Ping-pong sample bank

`default_nettype none

`include "pingpong_consts.svh"

module pingpong_bank
    import pingpong_pkg::*;
(
    input  logic    clk_i,
    input  logic    wr_en_i,     // Write strobe for this bank
    input  addr_t   wr_addr_i,
    input  sample_t wr_data_i,
    input  addr_t   rd_addr_i,   // Shared read address
    output sample_t rd_data_o    // Same-cycle read data
);

    // Sample storage
    sample_t mem_q [`PP_DEPTH];

    // Synchronous write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Asynchronous read, bypass style timing
    assign rd_data_o = mem_q[rd_addr_i];

endmodule

`default_nettype wire

// ==== rtl/pingpong_write_side.sv ====
// Ping-pong write side

`default_nettype none

`include "pingpong_consts.svh"

module pingpong_write_side
    import pingpong_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   write_valid_i,   // Writer has a sample
    output logic   write_ready_o,   // Room left in write bank
    input  logic   swap_i,          // Banks exchange roles at this edge
    input  logic   wr_sel_i,        // Bank currently being written
    output addr_t  wr_addr_o,
    output logic   wr_en0_o,
    output logic   wr_en1_o,
    output logic   wr_full_o,       // Write bank holds PP_DEPTH samples
    output count_t write_count_o
);

    addr_t  wr_addr_q;      // Next free slot
    count_t fill_q;         // Samples held in write bank
    logic   write_accept;   // Handshake completes this cycle

    // ==============================
    // Handshake
    // ==============================

    assign wr_full_o     = (fill_q == count_t'(`PP_DEPTH));
    assign write_ready_o = ~wr_full_o;                      // Stall only when full
    assign write_accept  = write_valid_i & write_ready_o;

    // Steer the accepted sample to the selected bank
    assign wr_en0_o = write_accept & ~wr_sel_i;
    assign wr_en1_o = write_accept & wr_sel_i;

    // ==============================
    // Address and fill count
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_addr_q <= '0;
            fill_q    <= '0;
        end else if (swap_i) begin
            wr_addr_q <= '0;                    // Fresh bank starts at slot 0
            fill_q    <= '0;
        end else if (write_accept) begin
            wr_addr_q <= wr_addr_q + 1'b1;      // Wraps to 0 after last slot
            fill_q    <= fill_q + 1'b1;
        end
    end

    assign wr_addr_o     = wr_addr_q;
    assign write_count_o = fill_q;

endmodule

`default_nettype wire

// ==== rtl/pingpong_swap_ctrl.sv ====
// Ping-pong swap controller

`default_nettype none

`include "pingpong_consts.svh"

module pingpong_swap_ctrl
    import pingpong_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic wr_full_i,       // Write bank has PP_DEPTH samples
    output logic swap_o,          // High for the single SWAP_PENDING cycle
    output logic wr_sel_o,        // Bank being written, 0 or 1
    output logic buffer_ready_o   // One-cycle pulse per filled bank
);

    buf_state_t state_q;
    buf_state_t state_d;
    logic       wr_sel_q;
    logic       buffer_ready_q;

    // ==============================
    // Next state
    // ==============================

    always_comb begin
        state_d = state_q;  // Hold by default
        case (state_q)
            WRITING: begin
                if (wr_full_i) begin
                    state_d = SWAP_PENDING;   // First bank just filled
                end
            end
            SWAP_PENDING: begin
                // Always a single cycle
                state_d = READING;
            end
            READING: begin
                if (wr_full_i) begin
                    state_d = SWAP_PENDING;   // Other bank filled meanwhile
                end
            end
            default: begin
                state_d = WRITING;
            end
        endcase
    end

    assign swap_o = (state_q == SWAP_PENDING);

    // ==============================
    // State, bank select and pulse
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q        <= WRITING;
            wr_sel_q       <= 1'b0;     // Bank 0 written first
            buffer_ready_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            buffer_ready_q <= swap_o;   // Pulse lands on the swap edge
            if (swap_o) begin
                wr_sel_q <= ~wr_sel_q;  // Full bank becomes read bank
            end
        end
    end

    assign wr_sel_o       = wr_sel_q;
    assign buffer_ready_o = buffer_ready_q;

endmodule

`default_nettype wire

// ==== rtl/pingpong_read_side.sv ====
// Ping-pong read side

`default_nettype none

`include "pingpong_consts.svh"

module pingpong_read_side
    import pingpong_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    swap_i,         // New bank becomes readable at this edge
    input  logic    wr_sel_i,       // Bank being written, read the other one
    input  sample_t bank0_data_i,
    input  sample_t bank1_data_i,
    output addr_t   rd_addr_o,      // Shared by both banks
    input  logic    read_ready_i,
    output logic    read_valid_o,
    output sample_t read_data_o,
    output count_t  read_count_o
);

    addr_t   rd_addr_q;
    count_t  rd_count_q;      // Samples consumed from current bank
    logic    rd_valid_q;
    logic    read_accept;     // Reader takes a sample this cycle
    logic    last_read;       // Consuming the final sample of the bank
    sample_t rd_bank_data;    // Data of the bank not being written

    // ==============================
    // Handshake
    // ==============================

    assign read_accept = rd_valid_q & read_ready_i;
    assign last_read   = (rd_count_q == count_t'(`PP_DEPTH - 1));

    // ==============================
    // Address, count and valid
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_addr_q  <= '0;
            rd_count_q <= '0;
            rd_valid_q <= 1'b0;
        end else if (swap_i) begin
            // Restart on the new bank, any unread rest is dropped
            rd_addr_q  <= '0;
            rd_count_q <= '0;
            rd_valid_q <= 1'b1;
        end else if (read_accept) begin
            rd_addr_q  <= rd_addr_q + 1'b1;
            rd_count_q <= rd_count_q + 1'b1;    // Parks at PP_DEPTH
            if (last_read) begin
                rd_valid_q <= 1'b0;             // Stays low until next swap
            end
        end
    end

    // ==============================
    // Output data
    // ==============================

    // Read bank is the opposite of the write bank
    assign rd_bank_data = wr_sel_i ? bank0_data_i : bank1_data_i;
    assign read_data_o  = rd_valid_q ? rd_bank_data : '0;   // Zero when idle

    assign rd_addr_o    = rd_addr_q;
    assign read_valid_o = rd_valid_q;
    assign read_count_o = rd_count_q;

endmodule

`default_nettype wire

// ==== rtl/pingpong_buffer.sv ====
// Ping-pong sample buffer top

`default_nettype none

`include "pingpong_consts.svh"

module pingpong_buffer
    import pingpong_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    // Write handshake
    input  sample_t write_data_i,
    input  logic    write_valid_i,
    output logic    write_ready_o,
    // Read handshake
    output sample_t read_data_o,
    input  logic    read_ready_i,
    output logic    read_valid_o,
    // Status
    output logic    buffer_ready_o,   // Pulse when a bank is ready to read
    output count_t  write_count_o,
    output count_t  read_count_o
);

    // ==============================
    // Internal nets
    // ==============================

    addr_t   wr_addr;
    logic    wr_en0;
    logic    wr_en1;
    logic    wr_full;
    logic    swap;
    logic    wr_sel;
    addr_t   rd_addr;
    sample_t bank0_data;
    sample_t bank1_data;

    // Input side
    pingpong_write_side u_write_side (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o),
        .swap_i        (swap),
        .wr_sel_i      (wr_sel),
        .wr_addr_o     (wr_addr),
        .wr_en0_o      (wr_en0),
        .wr_en1_o      (wr_en1),
        .wr_full_o     (wr_full),
        .write_count_o (write_count_o)
    );

    // Bank role control
    pingpong_swap_ctrl u_swap_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .wr_full_i      (wr_full),
        .swap_o         (swap),
        .wr_sel_o       (wr_sel),
        .buffer_ready_o (buffer_ready_o)
    );

    // Both banks see the same addresses, only the write strobe differs
    pingpong_bank u_bank0 (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en0),
        .wr_addr_i (wr_addr),
        .wr_data_i (write_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (bank0_data)
    );

    pingpong_bank u_bank1 (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en1),
        .wr_addr_i (wr_addr),
        .wr_data_i (write_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (bank1_data)
    );

    // Output side
    pingpong_read_side u_read_side (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .swap_i       (swap),
        .wr_sel_i     (wr_sel),
        .bank0_data_i (bank0_data),
        .bank1_data_i (bank1_data),
        .rd_addr_o    (rd_addr),
        .read_ready_i (read_ready_i),
        .read_valid_o (read_valid_o),
        .read_data_o  (read_data_o),
        .read_count_o (read_count_o)
    );

endmodule

`default_nettype wire

// ==== verif/pingpong_buffer_assert.sv ====
// Ping-pong buffer assertions

`default_nettype none

`include "pingpong_consts.svh"

module pingpong_buffer_assert
    import pingpong_pkg::*;
(
    input logic    clk_i,
    input logic    rst_ni,
    input logic    buffer_ready_i,
    input logic    write_ready_i,
    input count_t  write_count_i,
    input logic    read_valid_i,
    input sample_t read_data_i
);

    // ==============================
    // Handshake and swap rules
    // ==============================

    a_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        buffer_ready_i |=> !buffer_ready_i)
        else $error("buffer_ready_o high two cycles in a row");

    // Stall exactly at a full bank
    a_write_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!write_ready_i) == (write_count_i == count_t'(`PP_DEPTH)))
        else $error("write_ready_o disagrees with write_count_o");

    a_valid_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(read_valid_i) |-> buffer_ready_i)
        else $error("read_valid_o rose without buffer_ready_o");

    a_idle_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !read_valid_i |-> (read_data_i == '0))   // Output blanked when idle
        else $error("read_data_o nonzero while read_valid_o low");

endmodule

bind pingpong_buffer pingpong_buffer_assert u_pingpong_buffer_assert (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .buffer_ready_i (buffer_ready_o),
    .write_ready_i  (write_ready_o),
    .write_count_i  (write_count_o),
    .read_valid_i   (read_valid_o),
    .read_data_i    (read_data_o)
);

`default_nettype wire

// ==== verif/pingpong_buffer_tb.sv ====
// Ping-pong buffer testbench

`default_nettype none

`include "pingpong_consts.svh"

module pingpong_buffer_tb
    import pingpong_pkg::*;
();

    logic    clk;
    logic    rst_n;
    sample_t write_data;
    logic    write_valid;
    logic    write_ready;
    sample_t read_data;
    logic    read_ready;
    logic    read_valid;
    logic    buffer_ready;
    count_t  write_count;
    count_t  read_count;

    // ==============================
    // Reference model state
    // ==============================

    logic [31:0] rng = 32'd43;
    int      err_count = 0;
    int      tests_run = 0;
    int      tests_failed = 0;
    int      m_wcount = 0;      // Expected fill of the write bank
    int      m_rcount = 0;
    logic    m_rvalid = 1'b0;
    logic    m_brdy = 1'b0;
    int      swap_cnt = 0;      // Edges left until the swap, 0 when idle
    sample_t fill_q[$];         // Samples held in the write bank
    sample_t rd_q[$];           // Unread samples of the read bank
    sample_t cur_data = '0;     // Sample currently offered to the DUT
    int      writes_left = 0;
    int      read_goal = 0;     // Absolute read total to reach
    int      total_reads = 0;
    logic    w_acc = 1'b0;      // Handshakes due at the next edge
    logic    r_acc = 1'b0;

    pingpong_buffer u_pingpong_buffer (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .write_data_i   (write_data),
        .write_valid_i  (write_valid),
        .write_ready_o  (write_ready),
        .read_data_o    (read_data),
        .read_ready_i   (read_ready),
        .read_valid_o   (read_valid),
        .buffer_ready_o (buffer_ready),
        .write_count_o  (write_count),
        .read_count_o   (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // Period 40
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // High with probability 100 - gap_pct percent
    function automatic logic take_turn(input int gap_pct);
        rng = xorshift32(rng);
        return (rng % 100) >= gap_pct;
    endfunction

    function automatic sample_t new_sample();
        rng = xorshift32(rng);
        return sample_t'(rng[31:16]);
    endfunction

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_outputs();
        sample_t exp_data;
        exp_data = '0;                                  // Zero while idle
        if (m_rvalid && rd_q.size() > 0) begin
            exp_data = rd_q[0];
        end
        check_bit("write_ready_o", write_ready, m_wcount != `PP_DEPTH);
        check_count("write_count_o", write_count, count_t'(m_wcount));
        check_bit("buffer_ready_o", buffer_ready, m_brdy);
        check_bit("read_valid_o", read_valid, m_rvalid);
        check_count("read_count_o", read_count, count_t'(m_rcount));
        check_sample("read_data_o", read_data, exp_data);
    endtask

    // Apply the handshakes of the edge just passed
    task automatic update_model();
        m_brdy = 1'b0;
        if (swap_cnt == 1) begin
            rd_q = fill_q;                              // Unread rest is dropped
            fill_q.delete();
            m_wcount = 0;
            m_rcount = 0;
            m_rvalid = 1'b1;
            m_brdy   = 1'b1;
            swap_cnt = 0;
        end else begin
            if (swap_cnt == 2) begin
                swap_cnt = 1;                           // Swap pending
            end
            if (w_acc) begin
                fill_q.push_back(cur_data);
                cur_data = new_sample();
                writes_left--;
                m_wcount++;
                if (m_wcount == `PP_DEPTH) begin
                    swap_cnt = 2;
                end
            end
            if (r_acc) begin
                void'(rd_q.pop_front());
                total_reads++;
                m_rcount++;
                if (m_rcount == `PP_DEPTH) begin
                    m_rvalid = 1'b0;
                end
            end
        end
    endtask

    // Drive on the rising edge and check at the falling edge
    task automatic run_cycle(input logic wv, input logic rr);
        @(posedge clk);
        update_model();
        // Last sample waits until the reader is done
        write_valid <= wv && (writes_left > 0) && !(writes_left == 1 && total_reads < read_goal);
        write_data  <= cur_data;
        read_ready  <= rr && (total_reads < read_goal);
        @(negedge clk);
        compare_outputs();
        w_acc = write_valid && (m_wcount != `PP_DEPTH);
        r_acc = m_rvalid && read_ready;
    endtask

    task automatic run_traffic(input int n_write, input int n_read, input int gap_pct);
        int   cycles;
        logic wv;
        logic rr;
        writes_left = n_write;
        read_goal   = total_reads + n_read;
        cycles      = 0;
        while ((writes_left > 0 || total_reads < read_goal) && cycles < 400) begin
            wv = take_turn(gap_pct);
            rr = take_turn(gap_pct);
            run_cycle(wv, rr);
            cycles++;
        end
        if (cycles >= 400) begin
            $display("Error: traffic of %0d writes and %0d reads did not finish in 400 cycles",
                     n_write, n_read);
            err_count++;
        end
    endtask

    task automatic wait_buffer_ready(output int n);
        n = 0;
        do begin
            run_cycle(1'b0, 1'b0);
            n++;
        end while (!buffer_ready && n < 20);
        if (!buffer_ready) begin
            $display("Error: buffer_ready_o did not pulse within 20 cycles");
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d error(s)", name, err_count - errs_before);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic reset_state();
        int e0;
        e0 = err_count;
        check_bit("write_ready_o", write_ready, 1'b1);
        check_bit("read_valid_o", read_valid, 1'b0);
        check_bit("buffer_ready_o", buffer_ready, 1'b0);
        check_count("write_count_o", write_count, '0);
        check_count("read_count_o", read_count, '0);
        report_test("reset_state", e0);
    endtask

    task automatic fill_and_swap();
        int e0;
        int n;
        e0 = err_count;
        run_traffic(`PP_DEPTH, 0, 0);                   // Back to back
        check_count("write_count_o", write_count, count_t'(`PP_DEPTH));
        check_bit("write_ready_o", write_ready, 1'b0);
        wait_buffer_ready(n);
        check_count("buffer_ready_o delay", count_t'(n), count_t'(2));
        check_bit("read_valid_o", read_valid, 1'b1);
        check_count("write_count_o", write_count, '0);
        check_count("read_count_o", read_count, '0);
        check_bit("write_ready_o", write_ready, 1'b1);
        report_test("fill_and_swap", e0);
    endtask

    task automatic readback_order();
        int e0;
        e0 = err_count;
        run_traffic(0, `PP_DEPTH, 0);                   // Ready held high
        check_bit("read_valid_o", read_valid, 1'b0);
        check_count("read_count_o", read_count, count_t'(`PP_DEPTH));
        read_goal = total_reads + 3;                    // Reader keeps asking past the end
        repeat (3) begin
            run_cycle(1'b0, 1'b1);
            check_sample("read_data_o", read_data, '0);
        end
        report_test("readback_order", e0);
    endtask

    task automatic bank_alternation();
        int e0;
        int n;
        e0 = err_count;
        run_traffic(`PP_DEPTH, 0, 0);
        wait_buffer_ready(n);
        run_traffic(`PP_DEPTH, `PP_DEPTH, 0);           // Write one bank, read the other
        wait_buffer_ready(n);
        run_traffic(0, `PP_DEPTH, 0);
        report_test("bank_alternation", e0);
    endtask

    task automatic random_backpressure();
        int e0;
        int n;
        e0 = err_count;
        run_traffic(`PP_DEPTH, 0, 40);
        wait_buffer_ready(n);
        repeat (2) begin
            run_traffic(`PP_DEPTH, `PP_DEPTH, 40);
            wait_buffer_ready(n);
        end
        run_traffic(0, `PP_DEPTH, 40);
        report_test("random_backpressure", e0);
    endtask

    task automatic reader_overrun();
        int      e0;
        int      n;
        sample_t first;
        e0 = err_count;
        run_traffic(`PP_DEPTH, 0, 0);
        wait_buffer_ready(n);
        run_traffic(0, 5, 0);                           // Partial read only
        run_traffic(`PP_DEPTH, 0, 0);
        first = fill_q[0];
        wait_buffer_ready(n);
        check_count("read_count_o", read_count, '0);
        check_sample("read_data_o", read_data, first);
        run_traffic(0, `PP_DEPTH, 0);
        report_test("reader_overrun", e0);
    endtask

    initial begin
        rst_n       <= 1'b0;
        write_valid <= 1'b0;
        write_data  <= '0;
        read_ready  <= 1'b0;
        cur_data = new_sample();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_state();
        fill_and_swap();
        readback_order();
        bank_alternation();
        random_backpressure();
        reader_overrun();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
rtl/pingpong_pkg.sv
rtl/pingpong_bank.sv
rtl/pingpong_write_side.sv
rtl/pingpong_swap_ctrl.sv
rtl/pingpong_read_side.sv
rtl/pingpong_buffer.sv
verif/pingpong_buffer_assert.sv
verif/pingpong_buffer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ping-pong buffer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module pingpong_buffer_tb \
    -Mdir obj_dir \
    -o sim_pingpong

./obj_dir/sim_pingpong | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

echo "Testbench reported no failure"
